/* compile.f */
verilog/life_pkg.sv
verilog/life_grid_banks.sv
verilog/life_gen_engine.sv
verilog/life_frame_scanner.sv
verilog/life_core_top.sv
dv/life_assert.sv
dv/life_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module life_tb \
    -f compile.f \
    -o life_sim

./obj_dir/life_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Simulation failed" "$LOG" || ! grep -q "Simulation completed successfully" "$LOG"; then
    echo "Run FAILED, see $LOG"
    exit 1
fi
echo "Run passed"

/* dv/life_tb.sv */
`timescale 1ns/1ps

module life_tb;

    localparam int GRID_W         = 16;
    localparam int GRID_H         = 12;
    localparam int ROW_AW         = $clog2(GRID_H);
    localparam int NUM_GENS       = 10;
    // 16 checked frames of up to ~700 cycles each, plus loads and steps
    localparam int TIMEOUT_CYCLES = 20000;

    logic              out_stream_aclk;
    logic              axi_resetn;
    logic              load_req;
    logic [ROW_AW-1:0] load_row;
    logic [GRID_W-1:0] load_data;
    logic              load_ack;
    logic              step_req;
    logic              step_ack;
    life_pkg::pixel_t  pix_data;
    logic              pix_valid;
    logic              pix_ready;
    logic              pix_sof;
    logic              pix_last;

    int                seed = 77566;
    int                cycle_cnt = 0;
    logic [GRID_W-1:0] model [GRID_H];      // Expected grid, bit GRID_W-1 is column 0
    logic [GRID_W-1:0] rand_a [GRID_H];
    logic [GRID_W-1:0] rand_b [GRID_H];

    life_core_top #(.GRID_W(GRID_W), .GRID_H(GRID_H)) dut_i (
        .out_stream_aclk, .axi_resetn,
        .load_req, .load_row, .load_data, .load_ack,
        .step_req, .step_ack,
        .pix_data, .pix_valid, .pix_ready, .pix_sof, .pix_last
    );

    initial begin
        out_stream_aclk = 1'b0;
        forever #4 out_stream_aclk = ~out_stream_aclk;
    end

    // Sink is ready about 70% of the time
    initial begin
        pix_ready <= 1'b0;
        forever begin
            @(posedge out_stream_aclk);
            pix_ready <= ({$random(seed)} % 10) < 7;
        end
    end

    always @(posedge out_stream_aclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $fatal(1, "Timeout");
        end
    end

    // --------------------------------------------------
    // Checking and reference model
    // --------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error %s: got %h, expected %h", name, got, exp);
            $display("Simulation failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    function automatic logic cell_alive(int r, int c);
        if (r < 0 || r >= GRID_H || c < 0 || c >= GRID_W) begin
            return 1'b0;  // Outside the grid
        end
        return model[r][c];
    endfunction

    task automatic advance_model();
        logic [GRID_W-1:0] nxt [GRID_H];
        int                n;
        for (int r = 0; r < GRID_H; r++) begin
            for (int c = 0; c < GRID_W; c++) begin
                n = 0;
                for (int dr = -1; dr <= 1; dr++) begin
                    for (int dc = -1; dc <= 1; dc++) begin
                        if ((dr != 0 || dc != 0) && cell_alive(r + dr, c + dc)) n++;
                    end
                end
                nxt[r][c] = (n == 3) || (model[r][c] && n == 2);
            end
        end
        model = nxt;
    endtask

    task automatic check_pixel(int r, int c);
        life_pkg::pixel_t exp_pix;
        exp_pix = model[r][GRID_W-1-c] ? life_pkg::ALIVE_COLOR : life_pkg::DEAD_COLOR;
        check_value($sformatf("pix_data (row %0d, col %0d)", r, c),
                    32'(pix_data), 32'(exp_pix));
        check_value($sformatf("pix_sof (row %0d, col %0d)", r, c),
                    32'(pix_sof), 32'(r == 0 && c == 0));
        check_value($sformatf("pix_last (row %0d, col %0d)", r, c),
                    32'(pix_last), 32'(c == GRID_W - 1));
    endtask

    task automatic check_frame();
        logic prev_valid;
        logic fresh_sof;
        logic fetch_due;   // Row fetch cycle comes next
        int   k;
        prev_valid = 1'b1;
        fresh_sof  = 1'b0;
        fetch_due  = 1'b0;
        // First row of this frame must be fetched after the last bank update
        while (!fresh_sof) begin
            @(posedge out_stream_aclk);
            fresh_sof  = !prev_valid && pix_valid && pix_sof;
            prev_valid = pix_valid;
        end
        k = 0;
        while (k < GRID_W * GRID_H) begin
            // One idle fetch cycle after each row, valid otherwise
            check_value("pix_valid", 32'(pix_valid), 32'(!fetch_due));
            if (fetch_due) begin
                fetch_due = 1'b0;
            end else if (pix_ready) begin
                check_pixel(k / GRID_W, k % GRID_W);
                fetch_due = (k % GRID_W == GRID_W - 1);
                k++;
            end
            @(posedge out_stream_aclk);
        end
    endtask

    // --------------------------------------------------
    // Host handshakes
    // --------------------------------------------------
    task automatic load_model_grid();
        for (int r = 0; r < GRID_H; r++) begin
            @(posedge out_stream_aclk);
            check_value("load_ack", 32'(load_ack), 32'h0);
            load_row  <= ROW_AW'(r);
            load_data <= model[r];
            load_req  <= 1'b1;
            do @(posedge out_stream_aclk); while (!load_ack);
            load_req <= 1'b0;
            do @(posedge out_stream_aclk); while (load_ack);
        end
    endtask

    task automatic step_generation();
        @(posedge out_stream_aclk);
        check_value("step_ack", 32'(step_ack), 32'h0);
        step_req <= 1'b1;
        do @(posedge out_stream_aclk); while (!step_ack);
        step_req <= 1'b0;
        do @(posedge out_stream_aclk); while (step_ack);
        advance_model();
    endtask

    initial begin
        axi_resetn <= 1'b0;
        load_req   <= 1'b0;
        load_row   <= '0;
        load_data  <= '0;
        step_req   <= 1'b0;
        for (int r = 0; r < GRID_H; r++) begin
            rand_a[r] = GRID_W'($random(seed));
            rand_b[r] = GRID_W'($random(seed));
        end
        repeat (4) @(posedge out_stream_aclk);
        axi_resetn <= 1'b1;

        model = rand_a;
        load_model_grid();
        check_frame();
        step_generation();
        check_frame();

        // Blinker in column 1 touching the top edge
        for (int r = 0; r < GRID_H; r++) begin
            model[r] = (r < 3) ? GRID_W'(1) << (GRID_W - 2) : '0;
        end
        load_model_grid();
        check_frame();
        repeat (2) begin
            step_generation();
            check_frame();
        end

        model = rand_b;
        load_model_grid();
        check_frame();
        repeat (NUM_GENS) begin
            step_generation();
            check_frame();
        end

        if (dut_i.assert_i.fail_cnt != 0) begin
            $display("%0d assertion failures during the run", dut_i.assert_i.fail_cnt);
            $display("Simulation failed");
            $fatal(1, "Assertion failures");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

/* dv/life_assert.sv */
`timescale 1ns/1ps

module life_assert (
    input logic             out_stream_aclk,
    input logic             axi_resetn,
    input logic             load_req,
    input logic             load_ack,
    input logic             step_req,
    input logic             step_ack,
    input life_pkg::pixel_t pix_data,
    input logic             pix_valid,
    input logic             pix_ready,
    input logic             pix_sof,
    input logic             pix_last
);

    int unsigned fail_cnt = 0;  // Failures so far

    // --------------------------------------------------
    // Four-phase load and step ports
    // --------------------------------------------------
    a_ack_rise: assert property (@(posedge out_stream_aclk) disable iff (!axi_resetn)
        !($rose(load_ack) && !load_req) && !($rose(step_ack) && !step_req))
        else begin
            fail_cnt++;
            $error("ack rose without its request");
        end

    a_ack_fall: assert property (@(posedge out_stream_aclk) disable iff (!axi_resetn)
        !($fell(load_ack) && load_req) && !($fell(step_ack) && step_req))
        else begin
            fail_cnt++;
            $error("ack fell while its request was still high");
        end

    a_req_excl: assert property (@(posedge out_stream_aclk) disable iff (!axi_resetn)
        !(load_req && step_req))
        else begin
            fail_cnt++;
            $error("load_req and step_req high together");
        end

    // Stalled beat holds
    a_pix_hold: assert property (@(posedge out_stream_aclk) disable iff (!axi_resetn)
        (pix_valid && !pix_ready) |=> pix_valid && (pix_data === $past(pix_data))
            && (pix_sof === $past(pix_sof)) && (pix_last === $past(pix_last)))
        else begin
            fail_cnt++;
            $error("pixel beat changed while stalled");
        end

endmodule

bind life_core_top life_assert assert_i (
    .out_stream_aclk, .axi_resetn,
    .load_req, .load_ack, .step_req, .step_ack,
    .pix_data, .pix_valid, .pix_ready, .pix_sof, .pix_last
);

/* verilog/life_core_top.sv */
`timescale 1ns/1ps

module life_core_top #(
    parameter int GRID_W = 16,
    parameter int GRID_H = 12,
    localparam int ROW_AW = $clog2(GRID_H)
) (
    input  logic              out_stream_aclk,
    input  logic              axi_resetn,

    // Host load port
    input  logic              load_req,
    input  logic [ROW_AW-1:0] load_row,
    input  logic [GRID_W-1:0] load_data,
    output logic              load_ack,

    // Host step port
    input  logic              step_req,
    output logic              step_ack,

    // Pixel stream
    output life_pkg::pixel_t  pix_data,
    output logic              pix_valid,
    input  logic              pix_ready,
    output logic              pix_sof,
    output logic              pix_last
);

    // --------------------------------------------------
    // Engine and scanner links to the banks
    // --------------------------------------------------
    logic [ROW_AW-1:0] gen_rd_row;
    logic [GRID_W-1:0] gen_rd_data;
    logic              gen_wr_en;
    logic [ROW_AW-1:0] gen_wr_row;
    logic [GRID_W-1:0] gen_wr_data;
    logic              swap;        // Flips front and back banks
    logic [ROW_AW-1:0] disp_rd_row;
    logic [GRID_W-1:0] disp_rd_data;

    life_grid_banks #(.GRID_W(GRID_W), .GRID_H(GRID_H)) banks_i (
        .out_stream_aclk, .axi_resetn,
        .load_req, .load_row, .load_data, .load_ack,
        .gen_rd_row, .gen_rd_data,
        .gen_wr_en, .gen_wr_row, .gen_wr_data,
        .swap,
        .disp_rd_row, .disp_rd_data
    );

    life_gen_engine #(.GRID_W(GRID_W), .GRID_H(GRID_H)) engine_i (
        .out_stream_aclk, .axi_resetn,
        .step_req, .step_ack,
        .gen_rd_row, .gen_rd_data,
        .gen_wr_en, .gen_wr_row, .gen_wr_data,
        .swap
    );

    life_frame_scanner #(.GRID_W(GRID_W), .GRID_H(GRID_H)) scanner_i (
        .out_stream_aclk, .axi_resetn,
        .disp_rd_row, .disp_rd_data,
        .pix_data, .pix_valid, .pix_ready, .pix_sof, .pix_last
    );

endmodule

/* verilog/life_frame_scanner.sv */
`timescale 1ns/1ps

module life_frame_scanner #(
    parameter int GRID_W = 16,
    parameter int GRID_H = 12,
    localparam int ROW_AW = $clog2(GRID_H)
) (
    input  logic                 out_stream_aclk,
    input  logic                 axi_resetn,

    // Bank read
    output logic [ROW_AW-1:0]    disp_rd_row,
    input  logic [GRID_W-1:0]    disp_rd_data,

    // Pixel stream
    output life_pkg::pixel_t     pix_data,
    output logic                 pix_valid,
    input  logic                 pix_ready,
    output logic                 pix_sof,
    output logic                 pix_last
);

    localparam int XW = $clog2(GRID_W);

    typedef logic [GRID_W-1:0] row_t;

    logic [XW-1:0]     x;
    logic [ROW_AW-1:0] y;
    logic [ROW_AW-1:0] y_next;
    logic [XW-1:0]     bit_idx;
    logic              sending;   // Low during the fetch cycle of a row
    logic              last_col;
    row_t              row_q;     // Row being sent

    assign last_col = (x == XW'(GRID_W - 1));
    assign y_next   = (y == ROW_AW'(GRID_H - 1)) ? '0 : y + 1'b1;

    // Next row is addressed while the last beat waits, so the
    // fetch cycle finds it on the read port
    assign disp_rd_row = (sending && last_col) ? y_next : y;

    // --------------------------------------------------
    // Raster counters
    // --------------------------------------------------
    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn) begin
            x       <= '0;
            y       <= '0;
            sending <= 1'b0;
        end else if (!sending) begin
            sending <= 1'b1;
        end else if (pix_ready) begin
            if (last_col) begin
                x       <= '0;
                y       <= y_next;
                sending <= 1'b0;
            end else begin
                x <= x + 1'b1;
            end
        end
    end

    always_ff @(posedge out_stream_aclk) begin
        if (!sending) begin
            row_q <= disp_rd_data;
        end
    end

    // --------------------------------------------------
    // Pixel and flags
    // --------------------------------------------------
    // Leftmost pixel comes from the MSB
    assign bit_idx = XW'(GRID_W - 1) - x;

    assign pix_data  = row_q[bit_idx] ? life_pkg::ALIVE_COLOR : life_pkg::DEAD_COLOR;
    assign pix_valid = sending;
    assign pix_sof   = (x == '0) && (y == '0);
    assign pix_last  = last_col;   // End of row

endmodule

/* verilog/life_gen_engine.sv */
`timescale 1ns/1ps

module life_gen_engine #(
    parameter int GRID_W = 16,
    parameter int GRID_H = 12,
    localparam int ROW_AW = $clog2(GRID_H)
) (
    input  logic              out_stream_aclk,
    input  logic              axi_resetn,

    // Host step handshake
    input  logic              step_req,
    output logic              step_ack,

    // Bank access
    output logic [ROW_AW-1:0] gen_rd_row,
    input  logic [GRID_W-1:0] gen_rd_data,
    output logic              gen_wr_en,
    output logic [ROW_AW-1:0] gen_wr_row,
    output logic [GRID_W-1:0] gen_wr_data,
    output logic              swap
);

    typedef logic [GRID_W-1:0] row_t;

    life_pkg::gen_state_t gen_state;
    logic [ROW_AW-1:0]    rd_row;        // Address one step ahead of the window
    logic [ROW_AW-1:0]    rd_row_next;
    logic [ROW_AW-1:0]    wr_row;        // Row being computed
    logic                 prime_second;
    logic                 last_row;
    row_t                 top_r, mid_r, bot_r;
    row_t                 next_row;

    assign last_row    = (wr_row == ROW_AW'(GRID_H - 1));
    assign rd_row_next = (rd_row == ROW_AW'(GRID_H - 1)) ? rd_row : rd_row + 1'b1;

    assign gen_rd_row  = rd_row;
    assign gen_wr_row  = wr_row;
    assign gen_wr_data = next_row;
    assign gen_wr_en   = (gen_state == life_pkg::GEN_WRITE);
    assign swap        = (gen_state == life_pkg::GEN_SWAP);
    assign step_ack    = (gen_state == life_pkg::GEN_ACK);

    // --------------------------------------------------
    // Step sequencer
    // --------------------------------------------------
    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn) begin
            gen_state    <= life_pkg::GEN_IDLE;
            rd_row       <= '0;
            wr_row       <= '0;
            prime_second <= 1'b0;
        end else begin
            case (gen_state)
                life_pkg::GEN_IDLE: begin
                    if (step_req) begin  // Row 0 already on the read port
                        rd_row       <= rd_row_next;
                        wr_row       <= '0;
                        prime_second <= 1'b0;
                        gen_state    <= life_pkg::GEN_PRIME;
                    end
                end
                life_pkg::GEN_PRIME: begin
                    prime_second <= 1'b1;
                    if (prime_second) begin
                        gen_state <= life_pkg::GEN_WRITE;
                    end else begin
                        rd_row <= rd_row_next;
                    end
                end
                life_pkg::GEN_FETCH: begin
                    rd_row    <= rd_row_next;
                    gen_state <= life_pkg::GEN_WRITE;
                end
                life_pkg::GEN_WRITE: begin
                    if (last_row) begin
                        gen_state <= life_pkg::GEN_SWAP;
                    end else begin
                        wr_row    <= wr_row + 1'b1;
                        gen_state <= life_pkg::GEN_FETCH;
                    end
                end
                life_pkg::GEN_SWAP: begin
                    rd_row    <= '0;  // Park on row 0 for the next step
                    gen_state <= life_pkg::GEN_ACK;
                end
                life_pkg::GEN_ACK:  if (!step_req) gen_state <= life_pkg::GEN_IDLE;
                default:            gen_state <= life_pkg::GEN_IDLE;
            endcase
        end
    end

    // Three-row window, rows above and below the grid are dead
    always_ff @(posedge out_stream_aclk) begin
        if (gen_state == life_pkg::GEN_IDLE) begin
            top_r <= '0;
            mid_r <= '0;
            bot_r <= '0;
        end else if (gen_state == life_pkg::GEN_PRIME || gen_state == life_pkg::GEN_FETCH) begin
            top_r <= mid_r;
            mid_r <= bot_r;
            bot_r <= (gen_state == life_pkg::GEN_FETCH && last_row) ? '0 : gen_rd_data;
        end
    end

    // --------------------------------------------------
    // Next row, all cells at once
    // --------------------------------------------------
    logic [GRID_W+1:0] top_p, mid_p, bot_p;  // Dead column padding on both edges

    assign top_p = {1'b0, top_r, 1'b0};
    assign mid_p = {1'b0, mid_r, 1'b0};
    assign bot_p = {1'b0, bot_r, 1'b0};

    for (genvar i = 0; i < GRID_W; i++) begin : g_cell
        logic [3:0] n_cnt;

        assign n_cnt = 4'(top_p[i]) + 4'(top_p[i+1]) + 4'(top_p[i+2])
                     + 4'(mid_p[i]) + 4'(mid_p[i+2])
                     + 4'(bot_p[i]) + 4'(bot_p[i+1]) + 4'(bot_p[i+2]);
        // Birth on three, survival on two or three
        assign next_row[i] = (n_cnt == 4'd3) || (mid_r[i] && n_cnt == 4'd2);
    end

endmodule

/* verilog/life_grid_banks.sv */
`timescale 1ns/1ps

module life_grid_banks #(
    parameter int GRID_W = 16,
    parameter int GRID_H = 12,
    localparam int ROW_AW = $clog2(GRID_H)
) (
    input  logic              out_stream_aclk,
    input  logic              axi_resetn,

    // Host row load
    input  logic              load_req,
    input  logic [ROW_AW-1:0] load_row,
    input  logic [GRID_W-1:0] load_data,
    output logic              load_ack,

    // Generation engine
    input  logic [ROW_AW-1:0] gen_rd_row,
    output logic [GRID_W-1:0] gen_rd_data,
    input  logic              gen_wr_en,
    input  logic [ROW_AW-1:0] gen_wr_row,
    input  logic [GRID_W-1:0] gen_wr_data,
    input  logic              swap,

    // Frame scanner
    input  logic [ROW_AW-1:0] disp_rd_row,
    output logic [GRID_W-1:0] disp_rd_data
);

    typedef logic [GRID_W-1:0] row_t;

    row_t                  bank_mem [2][GRID_H];  // [bank][row]
    logic                  front_sel;             // Index of the front bank
    life_pkg::load_state_t load_state;
    logic                  load_wr;

    // --------------------------------------------------
    // Host load handshake
    // --------------------------------------------------
    assign load_wr  = (load_state == life_pkg::LOAD_IDLE) && load_req;
    assign load_ack = (load_state == life_pkg::LOAD_ACK);

    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn) begin
            load_state <= life_pkg::LOAD_IDLE;
        end else begin
            case (load_state)
                life_pkg::LOAD_IDLE: if (load_req) load_state <= life_pkg::LOAD_ACK;
                life_pkg::LOAD_ACK:  if (!load_req) load_state <= life_pkg::LOAD_IDLE;
                default:             load_state <= life_pkg::LOAD_IDLE;
            endcase
        end
    end

    // --------------------------------------------------
    // Bank select
    // --------------------------------------------------
    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn) begin
            front_sel <= 1'b0;
        end else if (swap) begin
            front_sel <= ~front_sel;
        end
    end

    // Loads land in the front bank, new generation in the back one
    always_ff @(posedge out_stream_aclk) begin
        if (load_wr && (int'(load_row) < GRID_H)) begin
            bank_mem[front_sel][load_row] <= load_data;
        end
        if (gen_wr_en) begin
            bank_mem[~front_sel][gen_wr_row] <= gen_wr_data;
        end
    end

    // Both read ports registered, one cycle latency
    always_ff @(posedge out_stream_aclk) begin
        gen_rd_data  <= bank_mem[front_sel][gen_rd_row];
        disp_rd_data <= bank_mem[front_sel][disp_rd_row];
    end

endmodule

/* verilog/life_pkg.sv */
package life_pkg;

    // --------------------------------------------------
    // Pixel format
    // --------------------------------------------------
    localparam int PIXEL_W = 24;

    typedef logic [PIXEL_W-1:0] pixel_t;  // {red, green, blue}

    // Dark red for dead cells, pale blue for live ones
    localparam pixel_t ALIVE_COLOR = {8'hCB, 8'hFF, 8'hFF};
    localparam pixel_t DEAD_COLOR  = {8'hCB, 8'h00, 8'h00};

    // --------------------------------------------------
    // Control state machines
    // --------------------------------------------------
    typedef enum logic [2:0] {
        GEN_IDLE,
        GEN_PRIME,   // Two row reads fill the window
        GEN_FETCH,
        GEN_WRITE,
        GEN_SWAP,
        GEN_ACK
    } gen_state_t;

    typedef enum logic {
        LOAD_IDLE,
        LOAD_ACK
    } load_state_t;

endpackage
